//--- files.f
hw/bkt_pkg.sv
hw/bkt_cmd_in.sv
hw/bkt_state_ram.sv
hw/bkt_engine.sv
hw/bkt_report.sv
hw/bkt_top.sv
tb/bkt_tb.sv

//--- run.sh
#!/bin/sh
# build the backtrack stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module bkt_tb -f files.f -o bkt_sim \
    && ./obj_dir/bkt_sim | grep "Regression passed" \
    || { echo "simulation did not pass"; exit 1; }

//--- tb/bkt_tb.sv
`timescale 1ns/1ps
// backtrack stage testbench
// fills the variable memory, runs each table row and checks the result,
// the rewritten memory image and the level record against a reference model

module bkt_tb;

    localparam int NROWS = 8;
    localparam int EXTRA = 4;
    localparam int CLK_PERIOD = 4;

    // name, variable count, target level, bin, fill level range, result hold cycles
    string row_name [NROWS] = '{"mid_level", "low_level", "top_level", "none_above",
                                "zero_vars", "same_level", "single_var", "wide_level"};
    int row_n    [NROWS] = '{64, 100, 48, 40, 0, 200, 1, 150};
    int row_lvl  [NROWS] = '{5, 1, 12, 20, 5, 5, 3, 300};
    int row_bin  [NROWS] = '{'h12a, 'h3ff, 'h055, 'h0f0, 'h001, 'h2c3, 'h111, 'h0aa};
    int row_lo   [NROWS] = '{0, 0, 8, 0, 0, 3, 3, 250};
    int row_hi   [NROWS] = '{9, 4, 12, 15, 9, 7, 3, 350};
    int row_hold [NROWS] = '{0, 3, 0, 2, 0, 4, 0, 1};

    logic                           clk;
    logic                           rst;
    logic                           cmd_valid_i;
    bkt_pkg::lvl_t                  cmd_lvl_i;
    bkt_pkg::bin_id_t               cmd_bin_i;
    bkt_pkg::var_addr_t             cmd_nvars_i;
    logic                           cmd_ready_o;
    logic                           res_valid_o;
    logic                           res_ready_i;
    bkt_pkg::var_addr_t             res_flips_o;
    bkt_pkg::var_addr_t             res_clears_o;
    logic                           host_vs_we_i;
    bkt_pkg::var_addr_t             host_vs_addr_i;
    bkt_pkg::var_state_t            host_vs_wdata_i;
    bkt_pkg::var_state_t            host_vs_rdata_o;
    logic [bkt_pkg::LVL_ADDR_W-1:0] host_ls_addr_i;
    bkt_pkg::lvl_state_t            host_ls_rdata_o;
    logic                           busy_o;

    // reference model state
    bkt_pkg::var_state_t shadow     [0:511];
    bkt_pkg::var_state_t expect_mem [0:511];
    bkt_pkg::lvl_state_t pre_ls;
    bkt_pkg::lvl_state_t exp_ls;
    int                  exp_flips;
    int                  exp_clears;
    integer              seed;
    string               cur_name;
    int                  errors = 0;
    int                  checks = 0;

    bkt_top dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp)
        else
        begin
            $display("FAILED %s %s: expected %h, actual %h", cur_name, what, exp, got);
            errors++;
        end
    endtask

    // random words for the row plus a few past the count, level record read on the side
    task automatic fill_vars(input int r);
        int                 k;
        int                 rnd;
        int                 span;
        bkt_pkg::assign_t   a;
        bkt_pkg::lvl_t      l;
        bkt_pkg::lvl_t      tgt;
        span = row_hi[r] - row_lo[r] + 1;
        tgt = bkt_pkg::lvl_t'(row_lvl[r]);
        host_ls_addr_i <= tgt[bkt_pkg::LVL_ADDR_W-1:0];
        for (k = 0; k < row_n[r] + EXTRA; k++)
        begin
            rnd = $random(seed);
            a = rnd[1] ? 2'b10 : 2'b01;
            shadow[k][$bits(bkt_pkg::lvl_t)] = rnd[0];
            rnd = $random(seed);
            l = bkt_pkg::lvl_t'(row_lo[r] + int'($unsigned(rnd) % span));
            shadow[k] = {a, shadow[k][$bits(bkt_pkg::lvl_t)], l};
            host_vs_we_i    <= 1'b1;
            host_vs_addr_i  <= bkt_pkg::var_addr_t'(k);
            host_vs_wdata_i <= shadow[k];
            @(posedge clk);
        end
        host_vs_we_i <= 1'b0;
        pre_ls = host_ls_rdata_o;
    endtask

    task automatic compute_expected(input int r);
        int                 k;
        bkt_pkg::assign_t   a;
        logic               imp;
        bkt_pkg::lvl_t      l;
        bkt_pkg::lvl_t      tgt;
        tgt = bkt_pkg::lvl_t'(row_lvl[r]);
        exp_flips = 0;
        exp_clears = 0;
        for (k = 0; k < row_n[r] + EXTRA; k++)
        begin
            {a, imp, l} = shadow[k];
            expect_mem[k] = shadow[k];
            if (k < row_n[r] && !imp && l == tgt)
            begin
                expect_mem[k] = {~a, imp, l};
                exp_flips++;
            end
            else if (k < row_n[r] && l >= tgt)
            begin
                expect_mem[k] = '0;
                exp_clears++;
            end
        end
        exp_ls = (exp_flips > 0) ? {bkt_pkg::bin_id_t'(row_bin[r]), 1'b1} : pre_ls;
    endtask

    // holds valid until the DUT takes the command
    task automatic send_cmd(input int lvl, input int bin, input int n);
        cmd_valid_i <= 1'b1;
        cmd_lvl_i   <= bkt_pkg::lvl_t'(lvl);
        cmd_bin_i   <= bkt_pkg::bin_id_t'(bin);
        cmd_nvars_i <= bkt_pkg::var_addr_t'(n);
        @(negedge clk);
        while (!cmd_ready_o)
            @(negedge clk);
        @(posedge clk);
        cmd_valid_i <= 1'b0;
    endtask

    task automatic wait_result(input int flips, input int clears);
        @(negedge clk);
        while (!res_valid_o)
            @(negedge clk);
        check_value("flips", 32'(flips), 32'(res_flips_o));
        check_value("clears", 32'(clears), 32'(res_clears_o));
    endtask

    task automatic accept_result();
        @(posedge clk);
        res_ready_i <= 1'b1;
        @(posedge clk);
        res_ready_i <= 1'b0;
    endtask

    // a zero count command waits behind the held result
    task automatic hold_result(input int r);
        int i;
        @(posedge clk);
        cmd_valid_i <= 1'b1;
        cmd_lvl_i   <= bkt_pkg::lvl_t'(row_lvl[r]);
        cmd_bin_i   <= bkt_pkg::bin_id_t'(row_bin[r]);
        cmd_nvars_i <= '0;
        for (i = 0; i < row_hold[r]; i++)
        begin
            @(negedge clk);
            check_value("held valid", 32'd1, 32'(res_valid_o));
            check_value("held flips", 32'(exp_flips), 32'(res_flips_o));
            check_value("held clears", 32'(exp_clears), 32'(res_clears_o));
            check_value("ready while pending", 32'd0, 32'(cmd_ready_o));
            check_value("busy while pending", 32'd0, 32'(busy_o));
            @(posedge clk);
        end
        res_ready_i <= 1'b1;
        @(posedge clk);
        res_ready_i <= 1'b0;
        send_cmd(row_lvl[r], row_bin[r], 0);
        wait_result(0, 0);
        accept_result();
    endtask

    task automatic read_back(input int r);
        int k;
        int total;
        total = row_n[r] + EXTRA;
        for (k = 0; k <= total; k++)
        begin
            if (k < total)
                host_vs_addr_i <= bkt_pkg::var_addr_t'(k);
            @(negedge clk);
            if (k > 0)
                check_value($sformatf("var %0d", k - 1), 32'(expect_mem[k - 1]),
                            32'(host_vs_rdata_o));
            @(posedge clk);
        end
        check_value("level record", 32'(exp_ls), 32'(host_ls_rdata_o));
    endtask

    initial
    begin
        int r;
        clk             = 1'b0;
        seed            = 32'hbd96_dc12;
        rst             <= 1'b0;
        cmd_valid_i     <= 1'b0;
        cmd_lvl_i       <= '0;
        cmd_bin_i       <= '0;
        cmd_nvars_i     <= '0;
        res_ready_i     <= 1'b0;
        host_vs_we_i    <= 1'b0;
        host_vs_addr_i  <= '0;
        host_vs_wdata_i <= '0;
        host_ls_addr_i  <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        cur_name = "reset";
        @(negedge clk);
        check_value("cmd_ready", 32'd1, 32'(cmd_ready_o));
        check_value("busy", 32'd0, 32'(busy_o));
        check_value("res_valid", 32'd0, 32'(res_valid_o));
        for (r = 0; r < NROWS; r++)
        begin
            cur_name = row_name[r];
            @(posedge clk);
            fill_vars(r);
            compute_expected(r);
            send_cmd(row_lvl[r], row_bin[r], row_n[r]);
            wait_result(exp_flips, exp_clears);
            if (row_hold[r] > 0)
                hold_result(r);
            else
                accept_result();
            read_back(r);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // budget of fill, sweep and readback per row
    initial
    begin
        int r;
        int budget;
        budget = 0;
        for (r = 0; r < NROWS; r++)
            budget += 3 * row_n[r] + 40;
        #(budget * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", budget);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- hw/bkt_top.sv
`timescale 1ns/1ps
// backtrack stage top
// command input, sweep engine, variable and level memories, result output

module bkt_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cmd_valid_i,
    input  bkt_pkg::lvl_t                   cmd_lvl_i,
    input  bkt_pkg::bin_id_t                cmd_bin_i,
    input  bkt_pkg::var_addr_t              cmd_nvars_i,
    output logic                            cmd_ready_o,
    output logic                            res_valid_o,
    input  logic                            res_ready_i,
    output bkt_pkg::var_addr_t              res_flips_o,
    output bkt_pkg::var_addr_t              res_clears_o,
    input  logic                            host_vs_we_i,
    input  bkt_pkg::var_addr_t              host_vs_addr_i,
    input  bkt_pkg::var_state_t             host_vs_wdata_i,
    output bkt_pkg::var_state_t             host_vs_rdata_o,
    input  logic [bkt_pkg::LVL_ADDR_W-1:0]  host_ls_addr_i,
    output bkt_pkg::lvl_state_t             host_ls_rdata_o,
    output logic                            busy_o
);

    logic                            start;
    logic                            done;
    logic                            res_pending;
    bkt_pkg::lvl_t                   eng_lvl;
    bkt_pkg::bin_id_t                eng_bin;
    bkt_pkg::var_addr_t              eng_nvars;
    logic                            apply;
    bkt_pkg::var_addr_t              vs_raddr;
    bkt_pkg::var_state_t             vs_rdata;
    logic                            vs_we;
    bkt_pkg::var_addr_t              vs_waddr;
    bkt_pkg::var_state_t             vs_wdata;
    logic                            ls_we;
    logic [bkt_pkg::LVL_ADDR_W-1:0]  ls_addr;
    bkt_pkg::lvl_state_t             ls_wdata;
    logic                            flip;
    logic                            clear;

    bkt_cmd_in cmd_in_i (
        .clk           (clk),
        .rst           (rst),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_lvl_i     (cmd_lvl_i),
        .cmd_bin_i     (cmd_bin_i),
        .cmd_nvars_i   (cmd_nvars_i),
        .cmd_ready_o   (cmd_ready_o),
        .res_pending_i (res_pending),
        .done_i        (done),
        .start_o       (start),
        .lvl_o         (eng_lvl),
        .bin_o         (eng_bin),
        .nvars_o       (eng_nvars),
        .busy_o        (busy_o)
    );

    bkt_engine engine_i (
        .clk        (clk),
        .rst        (rst),
        .start_i    (start),
        .lvl_i      (eng_lvl),
        .bin_i      (eng_bin),
        .nvars_i    (eng_nvars),
        .apply_o    (apply),
        .vs_raddr_o (vs_raddr),
        .vs_rdata_i (vs_rdata),
        .vs_we_o    (vs_we),
        .vs_waddr_o (vs_waddr),
        .vs_wdata_o (vs_wdata),
        .ls_we_o    (ls_we),
        .ls_addr_o  (ls_addr),
        .ls_wdata_o (ls_wdata),
        .flip_o     (flip),
        .clear_o    (clear),
        .done_o     (done)
    );

    // host writes are dropped for the whole command
    bkt_state_ram #(
        .WIDTH  ($bits(bkt_pkg::var_state_t)),
        .ADDR_W (bkt_pkg::VAR_ADDR_W)
    ) vs_ram_i (
        .clk          (clk),
        .eng_sel_i    (apply),
        .eng_raddr_i  (vs_raddr),
        .eng_rdata_o  (vs_rdata),
        .eng_we_i     (vs_we),
        .eng_waddr_i  (vs_waddr),
        .eng_wdata_i  (vs_wdata),
        .host_we_i    (host_vs_we_i && !busy_o),
        .host_addr_i  (host_vs_addr_i),
        .host_wdata_i (host_vs_wdata_i),
        .host_rdata_o (host_vs_rdata_o)
    );

    // level records are read back only, the engine is the sole writer
    bkt_state_ram #(
        .WIDTH  ($bits(bkt_pkg::lvl_state_t)),
        .ADDR_W (bkt_pkg::LVL_ADDR_W)
    ) ls_ram_i (
        .clk          (clk),
        .eng_sel_i    (apply),
        .eng_raddr_i  (ls_addr),
        .eng_rdata_o  (),
        .eng_we_i     (ls_we),
        .eng_waddr_i  (ls_addr),
        .eng_wdata_i  (ls_wdata),
        .host_we_i    (1'b0),
        .host_addr_i  (host_ls_addr_i),
        .host_wdata_i ('0),
        .host_rdata_o (host_ls_rdata_o)
    );

    bkt_report report_i (
        .clk           (clk),
        .rst           (rst),
        .flip_i        (flip),
        .clear_i       (clear),
        .done_i        (done),
        .res_valid_o   (res_valid_o),
        .res_ready_i   (res_ready_i),
        .res_flips_o   (res_flips_o),
        .res_clears_o  (res_clears_o),
        .res_pending_o (res_pending)
    );

endmodule

//--- hw/bkt_report.sv
`timescale 1ns/1ps
// result output
// counts flips and clears during a run and offers the totals over valid/ready

module bkt_report (
    input  logic                clk,
    input  logic                rst,
    input  logic                flip_i,
    input  logic                clear_i,
    input  logic                done_i,
    output logic                res_valid_o,
    input  logic                res_ready_i,
    output bkt_pkg::var_addr_t  res_flips_o,
    output bkt_pkg::var_addr_t  res_clears_o,
    output logic                res_pending_o
);

    bkt_pkg::var_addr_t flip_cnt;
    bkt_pkg::var_addr_t clr_cnt;

    // counters restart with every done
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            flip_cnt <= '0;
            clr_cnt  <= '0;
        end
        else if (done_i)
        begin
            flip_cnt <= '0;
            clr_cnt  <= '0;
        end
        else
        begin
            if (flip_i)
                flip_cnt <= flip_cnt + bkt_pkg::var_addr_t'(1);
            if (clear_i)
                clr_cnt <= clr_cnt + bkt_pkg::var_addr_t'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            res_valid_o <= 1'b0;
        else if (done_i)
            res_valid_o <= 1'b1;
        else if (res_ready_i)
            res_valid_o <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (done_i)
        begin
            res_flips_o  <= flip_cnt;
            res_clears_o <= clr_cnt;
        end
    end

    assign res_pending_o = res_valid_o;

    a_res_hold: assert property (@(posedge clk) disable iff (!rst)
        (res_valid_o && !res_ready_i) |=>
            (res_valid_o && $stable(res_flips_o) && $stable(res_clears_o)));

endmodule

//--- hw/bkt_engine.sv
`timescale 1ns/1ps
// backtrack sweep engine
// reads each active variable, flips decisions at the target level,
// clears everything else at or above it and marks the level record

module bkt_engine (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start_i,
    input  bkt_pkg::lvl_t                   lvl_i,
    input  bkt_pkg::bin_id_t                bin_i,
    input  bkt_pkg::var_addr_t              nvars_i,
    output logic                            apply_o,
    output bkt_pkg::var_addr_t              vs_raddr_o,
    input  bkt_pkg::var_state_t             vs_rdata_i,
    output logic                            vs_we_o,
    output bkt_pkg::var_addr_t              vs_waddr_o,
    output bkt_pkg::var_state_t             vs_wdata_o,
    output logic                            ls_we_o,
    output logic [bkt_pkg::LVL_ADDR_W-1:0]  ls_addr_o,
    output bkt_pkg::lvl_state_t             ls_wdata_o,
    output logic                            flip_o,
    output logic                            clear_o,
    output logic                            done_o
);

    bkt_pkg::eng_state_t state;
    bkt_pkg::eng_state_t state_nxt;
    bkt_pkg::var_addr_t  cnt;
    bkt_pkg::var_addr_t  last_idx;

    // read stage, data for rd_addr arrives this cycle
    logic                rd_vld;
    bkt_pkg::var_addr_t  rd_addr;
    bkt_pkg::assign_t    rd_asg;
    logic                rd_imp;
    bkt_pkg::lvl_t       rd_lvl;
    logic                flip_hit;
    logic                clr_hit;

    assign last_idx = nvars_i - bkt_pkg::var_addr_t'(1);

    always_comb
    begin
        state_nxt = state;
        case (state)
            bkt_pkg::IDLE:
                if (start_i)
                    state_nxt = (nvars_i == '0) ? bkt_pkg::DRAIN : bkt_pkg::SWEEP;
            bkt_pkg::SWEEP:
                if (cnt == last_idx)
                    state_nxt = bkt_pkg::DRAIN;
            bkt_pkg::DRAIN:
                // last write leaves the pipe this cycle
                if (!rd_vld)
                    state_nxt = bkt_pkg::IDLE;
            default:
                state_nxt = bkt_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state  <= bkt_pkg::IDLE;
            cnt    <= '0;
            rd_vld <= 1'b0;
            done_o <= 1'b0;
        end
        else
        begin
            state  <= state_nxt;
            rd_vld <= (state == bkt_pkg::SWEEP);
            done_o <= (state == bkt_pkg::DRAIN) && !rd_vld;
            if (state == bkt_pkg::SWEEP)
                cnt <= cnt + bkt_pkg::var_addr_t'(1);
            else
                cnt <= '0;
        end
    end

    always_ff @(posedge clk)
    begin
        rd_addr <= cnt;
    end

    assign apply_o    = (state != bkt_pkg::IDLE);
    assign vs_raddr_o = cnt;

    assign {rd_asg, rd_imp, rd_lvl} = vs_rdata_i;

    // decision at the target level flips, the rest at or above clears
    assign flip_hit = rd_vld && !rd_imp && (rd_lvl == lvl_i);
    assign clr_hit  = rd_vld && (rd_lvl >= lvl_i) && !flip_hit;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            vs_we_o <= 1'b0;
            ls_we_o <= 1'b0;
            flip_o  <= 1'b0;
            clear_o <= 1'b0;
        end
        else
        begin
            vs_we_o <= flip_hit || clr_hit;
            ls_we_o <= flip_hit;
            flip_o  <= flip_hit;
            clear_o <= clr_hit;
        end
    end

    always_ff @(posedge clk)
    begin
        vs_waddr_o <= rd_addr;
        if (flip_hit)
            vs_wdata_o <= {~rd_asg, rd_imp, rd_lvl};
        else
            vs_wdata_o <= '0;
    end

    // same record for every flip at this level
    assign ls_addr_o  = lvl_i[bkt_pkg::LVL_ADDR_W-1:0];
    assign ls_wdata_o = {bin_i, 1'b1};

    a_wr_under_apply: assert property (@(posedge clk) disable iff (!rst)
        (vs_we_o || ls_we_o) |->
            (apply_o && (state inside {bkt_pkg::SWEEP, bkt_pkg::DRAIN})));

    // each write belongs to a read issued two cycles earlier
    a_wr_after_read: assert property (@(posedge clk) disable iff (!rst)
        vs_we_o |-> $past(state == bkt_pkg::SWEEP, 2));

endmodule

//--- hw/bkt_state_ram.sv
`timescale 1ns/1ps
// state memory with one read and one write port
// the engine owns both ports while selected, otherwise the host does

module bkt_state_ram #(
    parameter int WIDTH  = 19,
    parameter int ADDR_W = 9
) (
    input  logic              clk,
    input  logic              eng_sel_i,
    input  logic [ADDR_W-1:0] eng_raddr_i,
    output logic [WIDTH-1:0]  eng_rdata_o,
    input  logic              eng_we_i,
    input  logic [ADDR_W-1:0] eng_waddr_i,
    input  logic [WIDTH-1:0]  eng_wdata_i,
    input  logic              host_we_i,
    input  logic [ADDR_W-1:0] host_addr_i,
    input  logic [WIDTH-1:0]  host_wdata_i,
    output logic [WIDTH-1:0]  host_rdata_o
);

    logic [WIDTH-1:0]  mem [0:(1<<ADDR_W)-1];
    logic [ADDR_W-1:0] raddr;
    logic              we;
    logic [ADDR_W-1:0] waddr;
    logic [WIDTH-1:0]  wdata;
    logic [WIDTH-1:0]  rdata_q;

    // port select
    always_comb
    begin
        if (eng_sel_i)
        begin
            raddr = eng_raddr_i;
            we    = eng_we_i;
            waddr = eng_waddr_i;
            wdata = eng_wdata_i;
        end
        else
        begin
            raddr = host_addr_i;
            we    = host_we_i;
            waddr = host_addr_i;
            wdata = host_wdata_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (we)
            mem[waddr] <= wdata;
        rdata_q <= mem[raddr];
    end

    // one read register shared by both sides
    assign eng_rdata_o  = rdata_q;
    assign host_rdata_o = rdata_q;

endmodule

//--- hw/bkt_cmd_in.sv
`timescale 1ns/1ps
// backtrack command input
// takes one command over valid/ready and holds it until the engine finishes

module bkt_cmd_in (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_valid_i,
    input  bkt_pkg::lvl_t       cmd_lvl_i,
    input  bkt_pkg::bin_id_t    cmd_bin_i,
    input  bkt_pkg::var_addr_t  cmd_nvars_i,
    output logic                cmd_ready_o,
    input  logic                res_pending_i,
    input  logic                done_i,
    output logic                start_o,
    output bkt_pkg::lvl_t       lvl_o,
    output bkt_pkg::bin_id_t    bin_o,
    output bkt_pkg::var_addr_t  nvars_o,
    output logic                busy_o
);

    logic full;
    logic xfer;

    // no new command while one runs or a result waits
    assign cmd_ready_o = !(full || res_pending_i);
    assign xfer        = cmd_valid_i && cmd_ready_o;
    assign busy_o      = full;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            full    <= 1'b0;
            start_o <= 1'b0;
        end
        else
        begin
            start_o <= xfer;
            if (xfer)
                full <= 1'b1;
            else if (done_i)
                full <= 1'b0;
        end
    end

    // command fields stay put until done
    always_ff @(posedge clk)
    begin
        if (xfer)
        begin
            lvl_o   <= cmd_lvl_i;
            bin_o   <= cmd_bin_i;
            nvars_o <= cmd_nvars_i;
        end
    end

    // done only ends a held command, never in its start cycle
    a_done_when_full: assert property (@(posedge clk) disable iff (!rst)
        done_i |-> (full && !start_o));

endmodule

//--- hw/bkt_pkg.sv
// backtrack stage shared definitions
// widths, memory word layouts and the engine state encoding

package bkt_pkg;

    // variable memory holds 512 entries
    localparam int VAR_ADDR_W = 9;

    // level memory is addressed by the low bits of a level
    localparam int LVL_ADDR_W = 9;

    // variable index, also used for the active variable count
    typedef logic [VAR_ADDR_W-1:0] var_addr_t;

    // decision level
    typedef logic [15:0] lvl_t;

    // clause bin id
    typedef logic [9:0] bin_id_t;

    // 00 unassigned, 01 false, 10 true
    typedef logic [1:0] assign_t;

    // {assign, implied, level}
    // implied == 0 means the variable was a decision
    typedef logic [$bits(assign_t)+1+$bits(lvl_t)-1:0] var_state_t;

    // {bin id, has_backtracked}
    typedef logic [$bits(bin_id_t):0] lvl_state_t;

    // sweep engine states
    typedef enum logic [1:0] {
        IDLE,
        SWEEP,
        DRAIN
    } eng_state_t;

endpackage
